// ==== rvAlu.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_config.svh"

module rvAlu (
    input  wire  [`XLEN-1:0] opA,
    input  wire  [`XLEN-1:0] opB,
    input  var rvPkg::aluOpT aluOp,
    output logic [`XLEN-1:0] result
);
    logic [4:0] shamt;
    logic       lessThan;

    assign shamt    = opB[4:0];
    assign lessThan = $signed(opA) < $signed(opB);

    always_comb begin
        case (aluOp)
            rvPkg::aluAdd: result = opA + opB;
            rvPkg::aluSub: result = opA - opB;
            rvPkg::aluAnd: result = opA & opB;
            rvPkg::aluOr:  result = opA | opB;
            rvPkg::aluXor: result = opA ^ opB;
            rvPkg::aluSlt: result = {{(`XLEN-1){1'b0}}, lessThan};
            rvPkg::aluSll: result = opA << shamt;
            rvPkg::aluSrl: result = opA >> shamt;
            rvPkg::aluSra: result = $signed(opA) >>> shamt;  // sign fill
            default:       result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rvChecker.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_config.svh"

module rvChecker (
    input wire                    clk,
    input wire                    rst_n,
    input wire                    dmemRen,
    input wire                    dmemWen,
    input wire [`WORD_ADDR_W-1:0] dmemAddr,
    input wire [`XLEN-1:0]        dmemWdata
);
    logic [`WORD_ADDR_W-1:0] expAddr [$];
    logic [`XLEN-1:0]        expData [$];
    int                      seen;
    int                      reads;
    int                      expReads;
    int                      errors;

    task automatic clearExpected(input int loads);
        expAddr.delete();
        expData.delete();
        seen = 0;
        reads = 0;
        expReads = loads;
        errors = 0;
    endtask

    task automatic addExpected(input logic [`WORD_ADDR_W-1:0] a, input logic [`XLEN-1:0] d);
        expAddr.push_back(a);
        expData.push_back(d);
    endtask

    function automatic bit allSeen();
        return seen >= expAddr.size();
    endfunction

    task automatic closeTest(output int errs);
        if (seen < expAddr.size()) begin
            $display("only %0d of %0d expected stores appeared", seen, expAddr.size());
            errors++;
        end
        if (reads != expReads) begin
            $display("%0d loads reached the data port, expected %0d", reads, expReads);
            errors++;
        end
        errs = errors;
    endtask

    // one cycle of dmemRen per executed load
    always @(posedge clk) begin
        if (rst_n && dmemRen) begin
            reads++;
        end
    end

    // stores are compared in program order
    always @(posedge clk) begin
        if (rst_n && dmemWen) begin
            if (seen >= expAddr.size()) begin
                $display("extra store of %h to word %h at %0t", dmemWdata, dmemAddr, $time);
                errors++;
            end else if (dmemAddr !== expAddr[seen] || dmemWdata !== expData[seen]) begin
                $display("[FAIL] %0t: store %0d wrote %h to word %h, expected %h to word %h",
                         $time, seen, dmemWdata, dmemAddr, expData[seen], expAddr[seen]);
                errors++;
            end
            seen++;
        end
    end

endmodule

`default_nettype wire

// ==== rvCore.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_config.svh"

module rvCore (
    input  wire                     clk,
    input  wire                     rst_n,
    output logic [`WORD_ADDR_W-1:0] imemAddr,
    input  wire  [`XLEN-1:0]        imemData,
    output logic                    dmemRen,
    output logic                    dmemWen,
    output logic [`WORD_ADDR_W-1:0] dmemAddr,
    output logic [`XLEN-1:0]        dmemWdata,
    input  wire  [`XLEN-1:0]        dmemRdata
);
    logic [`XLEN-1:0]       pc, ifIdInstr, ifIdPc;
    logic                   decRegWrite, decMemRead, decMemWrite, decAluSrcImm;
    logic                   decBranch, decJump, decBranchNe, decTaken;
    rvPkg::aluOpT           decAluOp;
    logic [`XLEN-1:0]       decImm, rfData1, rfData2, decOpA, decOpB, decTarget;
    logic [`REG_ADDR_W-1:0] decRs1, decRs2, decRd;
    logic                   stallFront, flushFetch;
    rvPkg::fwdSelT          fwdExA, fwdExB, fwdDecA, fwdDecB;
    logic                   idExRegWrite, idExMemRead, idExMemWrite, idExJump, idExAluSrcImm;
    rvPkg::aluOpT           idExAluOp;
    logic [`XLEN-1:0]       idExRs1Data, idExRs2Data, idExImm, idExLink;
    logic [`REG_ADDR_W-1:0] idExRs1, idExRs2, idExRd;
    logic [`XLEN-1:0]       exOpA, exRs2Fwd, exOpB, exResult;
    logic                   exMemRegWrite, exMemMemRead, exMemMemWrite, exMemJump;
    logic [`XLEN-1:0]       exMemAluResult, exMemStoreData, exMemLink, memFwdData;
    logic [`REG_ADDR_W-1:0] exMemRd, memWbRd;
    logic                   memWbRegWrite, memWbMemRead;
    logic [`XLEN-1:0]       memWbLoadData, memWbResult, wbData;

    function automatic logic [`XLEN-1:0] fwdMux(input rvPkg::fwdSelT sel,
                                               input logic [`XLEN-1:0] regVal,
                                               input logic [`XLEN-1:0] memVal,
                                               input logic [`XLEN-1:0] wbVal);
        case (sel)
            rvPkg::fwdMem: return memVal;
            rvPkg::fwdWb:  return wbVal;
            default:       return regVal;
        endcase
    endfunction

    assign imemAddr = pc[`WORD_ADDR_W+1:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc        <= `RESET_PC;
            ifIdInstr <= '0;
        end else if (!stallFront) begin
            pc        <= flushFetch ? decTarget : pc + 4;
            ifIdInstr <= flushFetch ? '0 : imemData;  // zero word decodes as bubble
        end
    end

    always_ff @(posedge clk) begin
        if (!stallFront) begin
            ifIdPc <= pc;
        end
    end

    rvDecoder decoder_i (
        .instr(ifIdInstr), .regWrite(decRegWrite), .memRead(decMemRead),
        .memWrite(decMemWrite), .aluSrcImm(decAluSrcImm), .branch(decBranch),
        .jump(decJump), .branchNe(decBranchNe), .aluOp(decAluOp), .imm(decImm),
        .rs1(decRs1), .rs2(decRs2), .rd(decRd)
    );

    rvRegFile regFile_i (
        .clk(clk), .rst_n(rst_n), .rs1(decRs1), .rs2(decRs2), .rd(memWbRd),
        .writeEn(memWbRegWrite), .writeData(wbData),
        .readData1(rfData1), .readData2(rfData2)
    );

    rvHazardUnit hazard_i (
        .decRs1(decRs1), .decRs2(decRs2), .exRs1(idExRs1), .exRs2(idExRs2),
        .exRd(idExRd), .memRd(exMemRd), .wbRd(memWbRd),
        .exRegWrite(idExRegWrite), .exMemRead(idExMemRead),
        .memRegWrite(exMemRegWrite), .memMemRead(exMemMemRead),
        .wbRegWrite(memWbRegWrite), .decBranch(decBranch), .decTaken(decTaken),
        .stallFront(stallFront), .flushFetch(flushFetch),
        .fwdExA(fwdExA), .fwdExB(fwdExB), .fwdDecA(fwdDecA), .fwdDecB(fwdDecB)
    );

    // branch resolved in decode
    assign decOpA    = fwdMux(fwdDecA, rfData1, memFwdData, wbData);
    assign decOpB    = fwdMux(fwdDecB, rfData2, memFwdData, wbData);
    assign decTaken  = decJump || (decBranch && ((decOpA == decOpB) != decBranchNe));
    assign decTarget = ifIdPc + decImm;

    always_ff @(posedge clk) begin
        if (!rst_n || stallFront) begin
            {idExRegWrite, idExMemRead, idExMemWrite, idExJump} <= '0;  // bubble
        end else begin
            {idExRegWrite, idExMemRead, idExMemWrite, idExJump} <=
                {decRegWrite, decMemRead, decMemWrite, decJump};
        end
    end

    always_ff @(posedge clk) begin
        idExAluOp     <= decAluOp;
        idExAluSrcImm <= decAluSrcImm;
        idExRs1Data   <= rfData1;
        idExRs2Data   <= rfData2;
        idExImm       <= decImm;
        idExLink      <= ifIdPc + 4;
        {idExRs1, idExRs2, idExRd} <= {decRs1, decRs2, decRd};
    end

    assign exOpA    = fwdMux(fwdExA, idExRs1Data, memFwdData, wbData);
    assign exRs2Fwd = fwdMux(fwdExB, idExRs2Data, memFwdData, wbData);
    assign exOpB    = idExAluSrcImm ? idExImm : exRs2Fwd;

    rvAlu alu_i (.opA(exOpA), .opB(exOpB), .aluOp(idExAluOp), .result(exResult));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            {exMemRegWrite, exMemMemRead, exMemMemWrite, exMemJump} <= '0;
        end else begin
            {exMemRegWrite, exMemMemRead, exMemMemWrite, exMemJump} <=
                {idExRegWrite, idExMemRead, idExMemWrite, idExJump};
        end
    end

    always_ff @(posedge clk) begin
        exMemAluResult <= exResult;
        exMemStoreData <= exRs2Fwd;
        exMemLink      <= idExLink;
        exMemRd        <= idExRd;
    end

    assign dmemRen    = exMemMemRead;
    assign dmemWen    = exMemMemWrite;
    assign dmemAddr   = exMemAluResult[`WORD_ADDR_W+1:2];
    assign dmemWdata  = exMemStoreData;
    assign memFwdData = exMemJump ? exMemLink : exMemAluResult;  // jal forwards its link

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            {memWbRegWrite, memWbMemRead} <= '0;
        end else begin
            {memWbRegWrite, memWbMemRead} <= {exMemRegWrite, exMemMemRead};
        end
    end

    always_ff @(posedge clk) begin
        memWbLoadData <= dmemRdata;
        memWbResult   <= memFwdData;
        memWbRd       <= exMemRd;
    end

    assign wbData = memWbMemRead ? memWbLoadData : memWbResult;

    oneDmemOp: assert property (@(posedge clk) disable iff (!rst_n) !(dmemRen && dmemWen))
        else $error("dmemRen and dmemWen high together");

endmodule

`default_nettype wire

// ==== rvDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_config.svh"

module rvDecoder (
    input  wire  [`XLEN-1:0]       instr,
    output logic                   regWrite,
    output logic                   memRead,
    output logic                   memWrite,
    output logic                   aluSrcImm,
    output logic                   branch,
    output logic                   jump,
    output logic                   branchNe,
    output rvPkg::aluOpT           aluOp,
    output logic [`XLEN-1:0]       imm,
    output logic [`REG_ADDR_W-1:0] rs1,
    output logic [`REG_ADDR_W-1:0] rs2,
    output logic [`REG_ADDR_W-1:0] rd
);
    rvPkg::opcodeT    opcode;
    logic [2:0]       funct3;
    logic [`XLEN-1:0] iImm, sImm, bImm, jImm;

    function automatic rvPkg::aluOpT aluSel(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? rvPkg::aluSub : rvPkg::aluAdd;
            3'b001:  return rvPkg::aluSll;
            3'b010:  return rvPkg::aluSlt;
            3'b100:  return rvPkg::aluXor;
            3'b101:  return alt ? rvPkg::aluSra : rvPkg::aluSrl;
            3'b110:  return rvPkg::aluOr;
            3'b111:  return rvPkg::aluAnd;
            default: return rvPkg::aluAdd;
        endcase
    endfunction

    assign opcode = rvPkg::opcodeT'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign iImm   = {{20{instr[31]}}, instr[31:20]};
    assign sImm   = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign bImm   = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign jImm   = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        {regWrite, memRead, memWrite, aluSrcImm, branch, jump, branchNe} = '0;
        aluOp = rvPkg::aluAdd;  // address and default add
        imm   = '0;
        rs1   = '0;
        rs2   = '0;
        rd    = '0;
        case (opcode)
            rvPkg::opOp: begin
                {regWrite, rs1, rs2, rd} = {1'b1, instr[19:15], instr[24:20], instr[11:7]};
                aluOp = aluSel(funct3, instr[30]);
            end
            rvPkg::opImm: begin
                {regWrite, aluSrcImm, rs1, rd, imm} = {2'b11, instr[19:15], instr[11:7], iImm};
                aluOp = aluSel(funct3, instr[30] && funct3 == 3'b101);  // only srai
            end
            rvPkg::opLoad: begin
                {regWrite, memRead, aluSrcImm} = 3'b111;
                {rs1, rd, imm} = {instr[19:15], instr[11:7], iImm};
            end
            rvPkg::opStore: begin
                {memWrite, aluSrcImm} = 2'b11;
                {rs1, rs2, imm} = {instr[19:15], instr[24:20], sImm};
            end
            rvPkg::opBranch: begin
                if (funct3[2:1] == 2'b00) begin  // beq, bne
                    {branch, branchNe} = {1'b1, funct3[0]};
                    {rs1, rs2, imm} = {instr[19:15], instr[24:20], bImm};
                end
            end
            rvPkg::opJal: begin
                {regWrite, jump, rd, imm} = {2'b11, instr[11:7], jImm};
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== rvHazardUnit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_config.svh"

module rvHazardUnit (
    input  wire [`REG_ADDR_W-1:0] decRs1,
    input  wire [`REG_ADDR_W-1:0] decRs2,
    input  wire [`REG_ADDR_W-1:0] exRs1,
    input  wire [`REG_ADDR_W-1:0] exRs2,
    input  wire [`REG_ADDR_W-1:0] exRd,
    input  wire [`REG_ADDR_W-1:0] memRd,
    input  wire [`REG_ADDR_W-1:0] wbRd,
    input  wire                   exRegWrite,
    input  wire                   exMemRead,
    input  wire                   memRegWrite,
    input  wire                   memMemRead,
    input  wire                   wbRegWrite,
    input  wire                   decBranch,
    input  wire                   decTaken,
    output logic                  stallFront,
    output logic                  flushFetch,
    output rvPkg::fwdSelT         fwdExA,
    output rvPkg::fwdSelT         fwdExB,
    output rvPkg::fwdSelT         fwdDecA,
    output rvPkg::fwdSelT         fwdDecB
);
    logic loadUse;
    logic branchOnEx;
    logic branchOnMemLoad;

    function automatic logic srcHit(input logic [`REG_ADDR_W-1:0] dst,
                                    input logic [`REG_ADDR_W-1:0] srcA,
                                    input logic [`REG_ADDR_W-1:0] srcB);
        return dst != '0 && (dst == srcA || dst == srcB);
    endfunction

    // memory stage wins over writeback, x0 never forwarded
    function automatic rvPkg::fwdSelT pickFwd(input logic [`REG_ADDR_W-1:0] src,
                                              input logic memWr,
                                              input logic [`REG_ADDR_W-1:0] mRd,
                                              input logic wbWr,
                                              input logic [`REG_ADDR_W-1:0] wRd);
        if (memWr && mRd != '0 && mRd == src) return rvPkg::fwdMem;
        if (wbWr && wRd != '0 && wRd == src) return rvPkg::fwdWb;
        return rvPkg::fwdNone;
    endfunction

    assign fwdExA  = pickFwd(exRs1, memRegWrite, memRd, wbRegWrite, wbRd);
    assign fwdExB  = pickFwd(exRs2, memRegWrite, memRd, wbRegWrite, wbRd);
    assign fwdDecA = pickFwd(decRs1, memRegWrite, memRd, 1'b0, wbRd);  // wb via RF bypass
    assign fwdDecB = pickFwd(decRs2, memRegWrite, memRd, 1'b0, wbRd);

    assign loadUse         = exMemRead && srcHit(exRd, decRs1, decRs2);
    assign branchOnEx      = decBranch && exRegWrite && srcHit(exRd, decRs1, decRs2);
    assign branchOnMemLoad = decBranch && memMemRead && srcHit(memRd, decRs1, decRs2);

    assign stallFront = loadUse || branchOnEx || branchOnMemLoad;
    assign flushFetch = decTaken && !stallFront;  // compare is stale while stalled

endmodule

`default_nettype wire

// ==== rvPkg.sv ====
`default_nettype none

package rvPkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        opLoad   = 7'b0000011,
        opImm    = 7'b0010011,
        opStore  = 7'b0100011,
        opOp     = 7'b0110011,
        opBranch = 7'b1100011,
        opJal    = 7'b1101111
    } opcodeT;

    typedef enum logic [3:0] {
        aluAdd = 4'd0,
        aluSub = 4'd1,
        aluAnd = 4'd2,
        aluOr  = 4'd3,
        aluXor = 4'd4,
        aluSlt = 4'd5,
        aluSll = 4'd6,
        aluSrl = 4'd7,
        aluSra = 4'd8
    } aluOpT;

    typedef enum logic [1:0] {
        fwdNone = 2'd0,  // value from the register file
        fwdMem  = 2'd1,  // result of the instruction in memory
        fwdWb   = 2'd2   // result being written back
    } fwdSelT;

endpackage

`default_nettype wire

// ==== rvRegFile.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_config.svh"

module rvRegFile (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire  [`REG_ADDR_W-1:0] rs1,
    input  wire  [`REG_ADDR_W-1:0] rs2,
    input  wire  [`REG_ADDR_W-1:0] rd,
    input  wire                    writeEn,
    input  wire  [`XLEN-1:0]       writeData,
    output logic [`XLEN-1:0]       readData1,
    output logic [`XLEN-1:0]       readData2
);
    logic [`XLEN-1:0] regs [`NUM_REGS];
    logic             doWrite;

    assign doWrite   = writeEn && rd != '0;  // x0 stays zero
    assign readData1 = (doWrite && rd == rs1) ? writeData : regs[rs1];
    assign readData2 = (doWrite && rd == rs2) ? writeData : regs[rs2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (doWrite) begin
            regs[rd] <= writeData;
        end
    end

    x0ReadsZero: assert property (@(posedge clk) disable iff (!rst_n)
        (rs1 != '0 || readData1 == '0) && (rs2 != '0 || readData2 == '0))
        else $error("x0 read returned a nonzero value");

endmodule

`default_nettype wire

// ==== rvTb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_config.svh"

module rvTb;
    // op codes {alt, funct3}: add sll slt xor srl or and sub sra
    localparam logic [35:0] aluCodeList = 36'hD8765_4210;

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic [`WORD_ADDR_W-1:0] imemAddr, dmemAddr;
    logic [`XLEN-1:0]        imemData, dmemRdata, dmemWdata;
    logic                    dmemRen, dmemWen;
    logic [`XLEN-1:0]        imem [64];
    logic [`XLEN-1:0]        dmem [64];
    logic [`WORD_ADDR_W-1:0] refAddr [$];
    logic [`XLEN-1:0]        refData [$];
    integer                  seed = 32'hfee1e2f9;
    int                      progLen, passCount, failCount, loadCount;

    always #2 clk = ~clk;

    assign imemData  = imem[imemAddr[5:0]];
    assign dmemRdata = dmem[dmemAddr[5:0]];

    always @(posedge clk) begin
        if (dmemWen) begin
            dmem[dmemAddr[5:0]] <= dmemWdata;
        end
    end

    rvCore dut_i (.clk(clk), .rst_n(rst_n), .imemAddr(imemAddr), .imemData(imemData),
        .dmemRen(dmemRen), .dmemWen(dmemWen), .dmemAddr(dmemAddr),
        .dmemWdata(dmemWdata), .dmemRdata(dmemRdata));

    rvChecker checker_i (.clk(clk), .rst_n(rst_n), .dmemRen(dmemRen), .dmemWen(dmemWen),
        .dmemAddr(dmemAddr), .dmemWdata(dmemWdata));

    function automatic logic [31:0] encR(input logic [3:0] code, input logic [4:0] rd, rs1, rs2);
        return {1'b0, code[3], 5'd0, rs2, rs1, code[2:0], rd, rvPkg::opOp};
    endfunction

    function automatic logic [31:0] encI(input rvPkg::opcodeT op, input logic [2:0] f3,
                                         input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encS(input logic [4:0] rs2, input logic [11:0] imm);
        return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], rvPkg::opStore};  // sw rs2, imm(x0)
    endfunction

    function automatic logic [31:0] encB(input logic ne, input logic [4:0] rs1, rs2,
                                         input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, 2'b00, ne, imm[4:1], imm[11], rvPkg::opBranch};
    endfunction

    function automatic logic [31:0] encJ(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rvPkg::opJal};
    endfunction

    function automatic void emit(input logic [31:0] word);
        imem[progLen] = word;
        progLen++;
    endfunction

    function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101: begin
                if (alt) return $unsigned($signed(a) >>> b[4:0]);
                return a >> b[4:0];
            end
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // instruction-level model, stops at the parking self loop
    function automatic int interpret();
        logic [31:0] x [`NUM_REGS];
        logic [31:0] mem [64];
        logic [31:0] pc, ins, a, b, imm, res, addr;
        int          steps;
        foreach (x[i]) x[i] = '0;
        foreach (mem[i]) mem[i] = dmem[i];
        pc = `RESET_PC;
        steps = 0;
        loadCount = 0;
        refAddr.delete();
        refData.delete();
        ins = imem[pc[7:2]];
        while (ins != encJ(5'd0, 21'd0) && steps < 400) begin
            a = x[ins[19:15]];
            b = x[ins[24:20]];
            imm = {{20{ins[31]}}, ins[31:20]};
            res = pc + 4;  // jal link
            case (ins[6:0])
                rvPkg::opOp:  res = aluRef(ins[14:12], ins[30], a, b);
                rvPkg::opImm: res = aluRef(ins[14:12], ins[30] && ins[14:12] == 3'b101, a, imm);
                rvPkg::opLoad: begin
                    addr = a + imm;
                    res = mem[addr[7:2]];
                    loadCount++;
                end
                rvPkg::opStore: begin
                    addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    mem[addr[7:2]] = b;
                    refAddr.push_back(addr[`WORD_ADDR_W+1:2]);
                    refData.push_back(b);
                end
                default: ;
            endcase
            if (ins[6:0] != rvPkg::opStore && ins[6:0] != rvPkg::opBranch && ins[11:7] != 0) begin
                x[ins[11:7]] = res;
            end
            if (ins[6:0] == rvPkg::opJal) begin
                pc = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end else if (ins[6:0] == rvPkg::opBranch && (a == b) != ins[12]) begin
                pc = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            end else begin
                pc = pc + 4;
            end
            steps++;
            ins = imem[pc[7:2]];
        end
        return steps;
    endfunction

    task automatic loadProgram(input int t);
        logic [3:0]  code;
        logic [11:0] imm;
        progLen = 0;
        foreach (imem[i]) begin
            imem[i] = '0;
            dmem[i] = $random(seed);
        end
        emit(encI(rvPkg::opLoad, 3'b010, 5'd1, 5'd0, 12'd0));
        emit(encI(rvPkg::opLoad, 3'b010, 5'd2, 5'd0, 12'd4));
        imm = $random(seed);
        case (t)
            0: begin
                for (int k = 0; k < 9; k++) begin
                    code = aluCodeList[4*k +: 4];
                    imm = $random(seed);
                    emit(encR(code, 5'd4, 5'd1, 5'd2));
                    emit(encS(5'd4, 12'(128 + 8 * k)));
                    if (code[1:0] == 2'b01) imm = {1'b0, code[3], 5'd0, imm[4:0]};  // shamt
                    if (code != 4'd8) begin  // no subi
                        emit(encI(rvPkg::opImm, code[2:0], 5'd5, 5'd1, imm));
                        emit(encS(5'd5, 12'(132 + 8 * k)));
                    end
                end
            end
            1: begin
                emit(encR(4'd8, 5'd4, 5'd1, 5'd2));
                emit(encR(4'd4, 5'd5, 5'd4, 5'd1));  // distance one
                emit(encI(rvPkg::opImm, 3'b000, 5'd6, 5'd4, imm));  // distance two
                emit(encR(4'd6, 5'd7, 5'd4, 5'd5));  // distance three
                emit(encR(4'd0, 5'd8, 5'd6, 5'd7));
                for (int r = 5; r <= 8; r++) emit(encS(5'(r), 12'(108 + 4 * r)));
            end
            2: begin
                emit(encI(rvPkg::opLoad, 3'b010, 5'd4, 5'd0, 12'd12));
                emit(encR(4'd0, 5'd5, 5'd4, 5'd4));
                emit(encS(5'd5, 12'd128));
                emit(encI(rvPkg::opLoad, 3'b010, 5'd6, 5'd0, 12'd16));
                emit(encS(5'd6, 12'd132));
            end
            3: begin
                emit(encR(4'd0, 5'd4, 5'd1, 5'd0));
                emit(encB(1'b0, 5'd4, 5'd1, 13'd8));  // taken
                emit(encS(5'd1, 12'd128));
                emit(encB(1'b1, 5'd4, 5'd1, 13'd8));  // not taken
                emit(encS(5'd2, 12'd132));
                emit(encI(rvPkg::opLoad, 3'b010, 5'd5, 5'd0, 12'd4));
                emit(encB(1'b0, 5'd5, 5'd1, 13'd8));  // load still in execute
                emit(encS(5'd5, 12'd136));
                emit(encI(rvPkg::opLoad, 3'b010, 5'd6, 5'd0, 12'd0));
                emit(encS(5'd2, 12'd140));
                emit(encB(1'b1, 5'd6, 5'd2, 13'd8));  // load now in memory
                emit(encS(5'd1, 12'd144));
                emit(encS(5'd6, 12'd148));
            end
            4: begin
                emit(encJ(5'd4, 21'd12));
                emit(encS(5'd1, 12'd128));
                emit(encS(5'd2, 12'd132));
                emit(encS(5'd4, 12'd136));
                emit(encR(4'd0, 5'd5, 5'd4, 5'd1));
                emit(encS(5'd5, 12'd140));
            end
            default: begin
                emit(encI(rvPkg::opImm, 3'b000, 5'd0, 5'd1, imm));
                emit(encR(4'd0, 5'd0, 5'd1, 5'd2));
                emit(encS(5'd0, 12'd128));
                emit(encR(4'd6, 5'd4, 5'd0, 5'd2));
                emit(encS(5'd4, 12'd132));
            end
        endcase
        emit(encJ(5'd0, 21'd0));  // park here
    endtask

    task automatic runTest(input int t);
        int steps, limit, cycles, errs;
        @(posedge clk);
        rst_n <= 1'b0;
        @(negedge clk);
        loadProgram(t);
        steps = interpret();
        limit = 8 * steps + 20;
        checker_i.clearExpected(loadCount);
        foreach (refAddr[i]) checker_i.addExpected(refAddr[i], refData[i]);
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        cycles = 0;
        while (!checker_i.allSeen() && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (cycles >= limit) $display("test %0d timed out after %0d cycles", t, cycles);
        repeat (8) @(negedge clk);  // catch a stray late store
        checker_i.closeTest(errs);
        if (errs == 0) begin
            passCount++;
            $display("test %0d passed, %0d stores", t, refAddr.size());
        end else begin
            failCount++;
            $display("test %0d failed, %0d errors", t, errs);
        end
    endtask

    initial begin
        rst_n = 1'b0;
        passCount = 0;
        failCount = 0;
        foreach (imem[i]) begin
            imem[i] = '0;
            dmem[i] = '0;
        end
        for (int t = 0; t < 6; t++) runTest(t);
        $display("passed %0d, failed %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rv_config.svh ====
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// data path width
`define XLEN 32

// register index width
`define REG_ADDR_W 5

// architectural registers x0..x31
`define NUM_REGS 32

// word address on both memory ports
`define WORD_ADDR_W 30

// first fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

// ==== sim.f ====
+incdir+.
rvPkg.sv
rvAlu.sv
rvDecoder.sv
rvRegFile.sv
rvHazardUnit.sv
rvCore.sv
rvChecker.sv
rvTb.sv
